// File: list.f
vlsu_pkg.sv
lsu_ctrl_if.sv
vlsu_fsm.sv
vlsu_beat_counter.sv
vlsu_store_path.sv
vlsu_load_path.sv
vlsu_top.sv
tb_bank_mem.sv
tb_vlsu.sv

// File: tb_vlsu.sv
//~~~~~~~~~~~~~~~~~~~~
// testbench for the vector load/store unit
// random loads and stores against a bank model,
// handshake timing checks and a watchdog
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_vlsu import vlsu_pkg::*; ();

    localparam int NUM_TXN = 300;
    localparam int CLK_NS  = 10;
    localparam int ROWS    = 2 ** ADDR_W;
    // a transaction needs under 12 cycles, twice that for the whole run
    localparam int WDOG_NS = NUM_TXN * 12 * CLK_NS * 2;

    logic              clk;
    logic              nrst;
    logic              req_valid;
    logic              req_ready;
    logic              req_op;
    logic [LMUL_W-1:0] req_lmul;
    logic [ADDR_W-1:0] req_addr;
    logic [VGRP_W-1:0] req_wdata;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [VGRP_W-1:0] rsp_rdata;
    logic              mem_en;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [BANK_W-1:0] mem_wdata0;
    logic [BANK_W-1:0] mem_wdata1;
    logic [BANK_W-1:0] mem_wdata2;
    logic [BANK_W-1:0] mem_wdata3;
    logic [BANK_W-1:0] mem_rdata0;
    logic [BANK_W-1:0] mem_rdata1;
    logic [BANK_W-1:0] mem_rdata2;
    logic [BANK_W-1:0] mem_rdata3;

    // reference copy of the four banks
    logic [BANK_W-1:0] model_mem [NUM_BANKS][ROWS];
    integer            seed;

    vlsu_top vlsu_top_inst (.*);

    tb_bank_mem bank_mem_inst (
        .clk    (clk),
        .en     (mem_en),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata0 (mem_wdata0),
        .wdata1 (mem_wdata1),
        .wdata2 (mem_wdata2),
        .wdata3 (mem_wdata3),
        .rdata0 (mem_rdata0),
        .rdata1 (mem_rdata1),
        .rdata2 (mem_rdata2),
        .rdata3 (mem_rdata3)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WDOG_NS);
        stop_on_error("watchdog expired, the run hung");
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [VGRP_W-1:0] expected,
                               input logic [VGRP_W-1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // same word pattern as the bank model starts with
    function automatic logic [BANK_W-1:0] fill_word(input int bank, input int row);
        fill_word = {4'(bank), 2'b00, 10'(row), 6'b101101, 10'(~row)};
    endfunction

    // registers in a group, reserved code acts as one
    function automatic int group_beats(input logic [1:0] lmul);
        case (lmul)
            2'd1:    group_beats = 2;
            2'd2:    group_beats = 4;
            default: group_beats = 1;
        endcase
    endfunction

    // beat k from row addr+k, zeros above the last beat
    function automatic logic [VGRP_W-1:0] expect_load(input logic [ADDR_W-1:0] addr,
                                                       input int beats);
        logic [ADDR_W-1:0] row;
        expect_load = '0;
        for (int k = 0; k < beats; k++) begin
            row = addr + ADDR_W'(k);
            for (int b = 0; b < NUM_BANKS; b++) begin
                expect_load[k*BEAT_W + b*BANK_W +: BANK_W] = model_mem[b][row];
            end
        end
    endfunction

    task automatic run_txn(input logic op, input logic [1:0] lmul,
                           input logic [ADDR_W-1:0] addr, input logic [VGRP_W-1:0] wdata,
                           input int delay);
        int                beats;
        int                edges;
        int                en_cnt;
        int                we_cnt;
        logic [ADDR_W-1:0] row;
        logic [VGRP_W-1:0] exp_data;
        logic [VGRP_W-1:0] held;
        beats    = group_beats(lmul);
        exp_data = expect_load(addr, beats);
        req_valid = 1'b1;
        req_op    = op;
        req_lmul  = lmul;
        req_addr  = addr;
        req_wdata = wdata;
        check_value("idle_req_ready", 1, req_ready);
        @(posedge clk);
        // accept edge, model takes the store now
        if (op == OP_STORE) begin
            for (int k = 0; k < beats; k++) begin
                row = addr + ADDR_W'(k);
                for (int b = 0; b < NUM_BANKS; b++) begin
                    model_mem[b][row] = wdata[k*BEAT_W + b*BANK_W +: BANK_W];
                end
            end
        end
        #1;
        req_valid = 1'b0;
        // scramble the request fields, the dut must have latched them
        req_op    = 1'($random(seed));
        req_lmul  = LMUL_W'($random(seed));
        req_addr  = ADDR_W'($random(seed));
        req_wdata = {16{$random(seed)}};
        // the accept edge counts as edge one
        edges  = 1;
        en_cnt = 0;
        we_cnt = 0;
        while (!rsp_valid) begin
            check_value("busy_req_ready", 0, req_ready);
            if (mem_en) begin
                check_value("mem_addr", ADDR_W'(addr + en_cnt), mem_addr);
                en_cnt++;
            end
            if (mem_we) begin
                we_cnt++;
            end
            @(posedge clk);
            #1;
            edges++;
            if (edges > 16) begin
                stop_on_error("rsp_valid never rose after an accepted request");
            end
        end
        check_value("rsp_valid_edge", beats + 2, edges);
        check_value("mem_en_beats", beats, en_cnt);
        check_value("mem_we_beats", (op == OP_STORE) ? beats : 0, we_cnt);
        if (op == OP_LOAD) begin
            check_value("load_data", exp_data, rsp_rdata);
        end
        held = rsp_rdata;
        // back-pressure, response must hold
        repeat (delay) begin
            @(posedge clk);
            #1;
            check_value("hold_rsp_valid", 1, rsp_valid);
            check_value("hold_rsp_rdata", held, rsp_rdata);
            check_value("hold_req_ready", 0, req_ready);
        end
        rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        rsp_ready = 1'b0;
        check_value("done_rsp_valid", 0, rsp_valid);
        check_value("done_req_ready", 1, req_ready);
    endtask

    initial begin
        logic [31:0]       rnd;
        logic              op;
        logic [1:0]        lmul;
        logic [ADDR_W-1:0] addr;
        logic [VGRP_W-1:0] wdata;
        logic              last_store;
        logic [1:0]        last_lmul;
        logic [ADDR_W-1:0] last_addr;
        int                delay;
        seed      = 26657;
        nrst      = 1'b0;
        req_valid = 1'b0;
        req_op    = 1'b0;
        req_lmul  = '0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                model_mem[b][r] = fill_word(b, r);
            end
        end
        repeat (16) @(posedge clk);
        #1;
        nrst = 1'b1;
        check_value("reset_req_ready", 1, req_ready);
        check_value("reset_rsp_valid", 0, rsp_valid);
        check_value("reset_mem_en", 0, mem_en);
        check_value("reset_mem_we", 0, mem_we);
        last_store = 1'b0;
        last_lmul  = '0;
        last_addr  = '0;
        for (int t = 0; t < NUM_TXN; t++) begin
            rnd  = $random(seed);
            op   = rnd[9];
            lmul = rnd[1:0];
            // low rows, or the top rows so the row address wraps
            addr = rnd[2] ? ADDR_W'(ROWS - 8 + rnd[5:3]) : ADDR_W'(rnd[8:4]);
            // read back a fresh store now and then
            if (last_store && rnd[10]) begin
                op   = OP_LOAD;
                lmul = last_lmul;
                addr = last_addr;
            end
            delay = rnd[15:12] % 5;
            for (int w = 0; w < VGRP_W / 32; w++) begin
                wdata[w*32 +: 32] = $random(seed);
            end
            run_txn(op, lmul, addr, wdata, delay);
            last_store = (op == OP_STORE);
            last_lmul  = lmul;
            last_addr  = addr;
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: tb_bank_mem.sv
//~~~~~~~~~~~~~~~~~~~~
// four-bank memory model for the testbench
// shared row address, one-cycle read latency
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_bank_mem import vlsu_pkg::*; (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [BANK_W-1:0] wdata0,
    input  logic [BANK_W-1:0] wdata1,
    input  logic [BANK_W-1:0] wdata2,
    input  logic [BANK_W-1:0] wdata3,
    output logic [BANK_W-1:0] rdata0,
    output logic [BANK_W-1:0] rdata1,
    output logic [BANK_W-1:0] rdata2,
    output logic [BANK_W-1:0] rdata3
);

    logic [BANK_W-1:0] mem [NUM_BANKS][2**ADDR_W];

    // every word carries its bank, its row and the inverted row
    initial begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int a = 0; a < 2**ADDR_W; a++) begin
                mem[b][a] = {4'(b), 2'b00, 10'(a), 6'b101101, 10'(~a)};
            end
        end
    end

    always @(posedge clk) begin
        // write lands on the enable edge
        if (en && we) begin
            mem[0][addr] <= wdata0;
            mem[1][addr] <= wdata1;
            mem[2][addr] <= wdata2;
            mem[3][addr] <= wdata3;
        end
        // read word shows up one cycle after the read
        if (en && !we) begin
            rdata0 <= mem[0][addr];
            rdata1 <= mem[1][addr];
            rdata2 <= mem[2][addr];
            rdata3 <= mem[3][addr];
        end
    end

endmodule

// File: vlsu_top.sv
//~~~~~~~~~~~~~~~~~~~~
// vector load/store data unit top level
// plain request, response and bank ports
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vlsu_top import vlsu_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    // request
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              req_op,
    input  logic [LMUL_W-1:0] req_lmul,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic [VGRP_W-1:0] req_wdata,
    // response
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [VGRP_W-1:0] rsp_rdata,
    // bank port, one row for all banks
    output logic              mem_en,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [BANK_W-1:0] mem_wdata0,
    output logic [BANK_W-1:0] mem_wdata1,
    output logic [BANK_W-1:0] mem_wdata2,
    output logic [BANK_W-1:0] mem_wdata3,
    input  logic [BANK_W-1:0] mem_rdata0,
    input  logic [BANK_W-1:0] mem_rdata1,
    input  logic [BANK_W-1:0] mem_rdata2,
    input  logic [BANK_W-1:0] mem_rdata3
);

    lsu_ctrl_if ctrl_if ();

    vlsu_fsm vlsu_fsm_inst (
        .clk       (clk),
        .nrst      (nrst),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .mem_en    (mem_en),
        .ctrl      (ctrl_if.fsm)
    );

    vlsu_beat_counter vlsu_beat_counter_inst (
        .clk      (clk),
        .nrst     (nrst),
        .req_lmul (req_lmul),
        .req_addr (req_addr),
        .mem_addr (mem_addr),
        .ctrl     (ctrl_if.counter)
    );

    vlsu_store_path vlsu_store_path_inst (
        .clk        (clk),
        .nrst       (nrst),
        .req_wdata  (req_wdata),
        .mem_we     (mem_we),
        .mem_wdata0 (mem_wdata0),
        .mem_wdata1 (mem_wdata1),
        .mem_wdata2 (mem_wdata2),
        .mem_wdata3 (mem_wdata3),
        .ctrl       (ctrl_if.store)
    );

    vlsu_load_path vlsu_load_path_inst (
        .clk        (clk),
        .nrst       (nrst),
        .mem_rdata0 (mem_rdata0),
        .mem_rdata1 (mem_rdata1),
        .mem_rdata2 (mem_rdata2),
        .mem_rdata3 (mem_rdata3),
        .rsp_rdata  (rsp_rdata),
        .ctrl       (ctrl_if.load)
    );

endmodule

// File: vlsu_load_path.sv
//~~~~~~~~~~~~~~~~~~~~
// load datapath
// bank read words collected into the 512-bit result
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vlsu_load_path import vlsu_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    input  logic [BANK_W-1:0] mem_rdata0,
    input  logic [BANK_W-1:0] mem_rdata1,
    input  logic [BANK_W-1:0] mem_rdata2,
    input  logic [BANK_W-1:0] mem_rdata3,
    output logic [VGRP_W-1:0] rsp_rdata,
    lsu_ctrl_if.load          ctrl
);

    // read data trails the read issue by one cycle
    logic                  cap_vld;
    logic [BEAT_IDX_W-1:0] cap_idx;
    logic [VGRP_W-1:0]     result;
    logic [BEAT_W-1:0]     rd_beat;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            cap_vld <= 1'b0;
        end else begin
            // only loads fill the result
            cap_vld <= ctrl.issue && !ctrl.is_store;
        end
    end

    always_ff @(posedge clk) begin
        cap_idx <= ctrl.beat_idx;
    end

    // bank 0 in the low word
    assign rd_beat = {mem_rdata3, mem_rdata2, mem_rdata1, mem_rdata0};

    // cleared on accept, so slots above the last beat read as zero
    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            result <= '0;
        end else if (cap_vld) begin
            result[cap_idx*BEAT_W +: BEAT_W] <= rd_beat;
        end
    end

    // untouched until the next accept, stable while the response waits
    assign rsp_rdata = result;

endmodule

// File: vlsu_store_path.sv
//~~~~~~~~~~~~~~~~~~~~
// store datapath
// register group slicing into bank write words
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vlsu_store_path import vlsu_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    input  logic [VGRP_W-1:0] req_wdata,
    output logic              mem_we,
    output logic [BANK_W-1:0] mem_wdata0,
    output logic [BANK_W-1:0] mem_wdata1,
    output logic [BANK_W-1:0] mem_wdata2,
    output logic [BANK_W-1:0] mem_wdata3,
    lsu_ctrl_if.store         ctrl
);

    // held copy of the register group
    logic [VGRP_W-1:0] wdata_q;
    logic [BEAT_W-1:0] beat_data;

    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            wdata_q <= req_wdata;
        end
    end

    // current beat, beat k is bits 128k up
    assign beat_data = wdata_q[ctrl.beat_idx*BEAT_W +: BEAT_W];

    // bank b takes word b of the beat
    assign mem_wdata0 = beat_data[0*BANK_W +: BANK_W];
    assign mem_wdata1 = beat_data[1*BANK_W +: BANK_W];
    assign mem_wdata2 = beat_data[2*BANK_W +: BANK_W];
    assign mem_wdata3 = beat_data[3*BANK_W +: BANK_W];

    // write strobe in the same cycle as the beat
    assign mem_we = ctrl.issue && ctrl.is_store;

    // a bank write always carries a defined beat of the latched group
    a_we_data_known: assert property (
        @(posedge clk) disable iff (!nrst)
        mem_we |-> !$isunknown(beat_data)
    );

endmodule

// File: vlsu_beat_counter.sv
//~~~~~~~~~~~~~~~~~~~~
// beat counter and bank row address generator
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vlsu_beat_counter import vlsu_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    input  logic [LMUL_W-1:0] req_lmul,
    input  logic [ADDR_W-1:0] req_addr,
    output logic [ADDR_W-1:0] mem_addr,
    lsu_ctrl_if.counter       ctrl
);

    // base row of the transfer
    logic [ADDR_W-1:0]     base_addr;
    // beats in this transfer, 1, 2 or 4
    logic [BEAT_IDX_W:0]   beat_cnt;
    logic [BEAT_IDX_W-1:0] beat_idx;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            beat_idx <= '0;
            beat_cnt <= 3'd1;
        end else if (ctrl.start) begin
            beat_idx <= '0;
            beat_cnt <= lmul_beats(req_lmul);
        end else if (ctrl.issue) begin
            // wraps to 0 after the fourth beat, ready for the next request
            beat_idx <= beat_idx + 1'b1;
        end
    end

    // base row is payload, only loaded on accept
    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            base_addr <= req_addr;
        end
    end

    assign ctrl.beat_idx  = beat_idx;
    assign ctrl.last_beat = ({1'b0, beat_idx} == (beat_cnt - 1'b1));

    // beat k reads or writes row base + k in every bank
    assign mem_addr = base_addr + ADDR_W'(beat_idx);

    // the fsm leaves issue on last_beat, so the index stays inside the group
    a_beat_range: assert property (
        @(posedge clk) disable iff (!nrst)
        ctrl.issue |-> ({1'b0, beat_idx} < beat_cnt)
    );

endmodule

// File: vlsu_fsm.sv
//~~~~~~~~~~~~~~~~~~~~
// transfer state machine
// request and response valid/ready handshake,
// bank enable and beat issue control
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vlsu_fsm import vlsu_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       req_valid,
    input  logic       req_op,
    output logic       req_ready,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output logic       mem_en,
    lsu_ctrl_if.fsm    ctrl
);

    logic [ST_W-1:0] state;
    logic [ST_W-1:0] state_nxt;
    logic            is_store_q;

    // one request at a time, the bank port is ours for the whole transfer
    assign req_ready = (state == ST_IDLE);
    assign ctrl.start = req_valid && req_ready;

    // every issue cycle is one bank access
    assign ctrl.issue = (state == ST_ISSUE);
    assign mem_en     = ctrl.issue;

    // response is held in its own state, so valid stays up under back-pressure
    assign rsp_valid = (state == ST_RESP);

    assign ctrl.is_store = is_store_q;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (ctrl.start) begin
                    state_nxt = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                // beat counter flags the final beat
                if (ctrl.last_beat) begin
                    state_nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                // last read word lands this cycle
                state_nxt = ST_RESP;
            end
            ST_RESP: begin
                if (rsp_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state      <= ST_IDLE;
            is_store_q <= 1'b0;
        end else begin
            state <= state_nxt;
            // op is held until the next accept
            if (ctrl.start) begin
                is_store_q <= (req_op == OP_STORE);
            end
        end
    end

    // a pending response is never withdrawn
    a_rsp_hold: assert property (
        @(posedge clk) disable iff (!nrst)
        (rsp_valid && !rsp_ready) |=> rsp_valid
    );

endmodule

// File: lsu_ctrl_if.sv
//~~~~~~~~~~~~~~~~~~~~
// control bundle from the fsm and beat counter
// to the store and load datapaths
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface lsu_ctrl_if import vlsu_pkg::*; ();

    // accept cycle of a new request
    logic                  start;
    // one beat goes out to the banks this cycle
    logic                  issue;
    // op of the transfer in flight
    logic                  is_store;
    // beat number, 0 in the first issue cycle
    logic [BEAT_IDX_W-1:0] beat_idx;
    // beat_idx points at the final beat
    logic                  last_beat;

    modport fsm (
        output start,
        output issue,
        output is_store,
        input  last_beat
    );

    modport counter (
        input  start,
        input  issue,
        output beat_idx,
        output last_beat
    );

    // both datapaths only listen
    modport store (input start, input issue, input is_store, input beat_idx);

    modport load (input start, input issue, input is_store, input beat_idx);

endinterface

// File: vlsu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// vector load/store unit shared definitions
// bank and beat geometry, request op and lmul codes,
// transfer fsm state codes, lmul to beat count helper
//~~~~~~~~~~~~~~~~~~~~

package vlsu_pkg;

    // bank geometry
    localparam int NUM_BANKS  = 4;
    localparam int BANK_W     = 32;
    // one beat is one word from every bank, same row
    localparam int BEAT_W     = NUM_BANKS * BANK_W;
    localparam int MAX_BEATS  = 4;
    localparam int VGRP_W     = MAX_BEATS * BEAT_W;
    localparam int BEAT_IDX_W = 2;
    localparam int ADDR_W     = 10;

    // request op, one bit
    localparam logic OP_LOAD  = 1'b0;
    localparam logic OP_STORE = 1'b1;

    // lmul codes, 2'd3 is reserved and treated as lmul 1
    localparam int   LMUL_W = 2;
    localparam logic [LMUL_W-1:0] LMUL_1 = 2'd0;
    localparam logic [LMUL_W-1:0] LMUL_2 = 2'd1;
    localparam logic [LMUL_W-1:0] LMUL_4 = 2'd2;

    // transfer fsm states
    localparam int   ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [ST_W-1:0] ST_ISSUE = 2'd1;
    localparam logic [ST_W-1:0] ST_DRAIN = 2'd2;
    localparam logic [ST_W-1:0] ST_RESP  = 2'd3;

    // number of 128-bit beats in a register group
    function automatic logic [BEAT_IDX_W:0] lmul_beats(input logic [LMUL_W-1:0] lmul);
        case (lmul)
            LMUL_2:  lmul_beats = 3'd2;
            LMUL_4:  lmul_beats = MAX_BEATS[BEAT_IDX_W:0];
            // LMUL_1 and the reserved code
            default: lmul_beats = 3'd1;
        endcase
    endfunction

endpackage
